/* common/drbg_settings.svh */
`ifndef DRBG_SETTINGS_SVH
`define DRBG_SETTINGS_SVH

// Width of K, V, private key, message hash and nonce
`define DRBG_REG_SIZE 384

// Mode 0 seed width
`define DRBG_SEED_SIZE 384

// Request counter, one byte in the formatted blocks
`define DRBG_CNT_SIZE 8

// P-384 group order n
`define DRBG_P384_ORDER {192'hFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF, \
                         192'hC7634D81F4372DDF581A0DB248B0A77AECEC196ACCC52973}

`endif

/* common/sha_pkg.sv */
package sha_pkg;

  localparam int sha_digest_w = 384;  // SHA-384 truncated digest

  typedef logic [63:0] sha_word_t;

  // Chaining value or working registers, a is the top word
  typedef struct packed {
    sha_word_t a;
    sha_word_t b;
    sha_word_t c;
    sha_word_t d;
    sha_word_t e;
    sha_word_t f;
    sha_word_t g;
    sha_word_t h;
  } sha_state_t;

  // ----------------------------------------------------------------------
  // Block layout seen by the DRBG and HMAC formatting
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [sha_digest_w-1:0] v;    // V, or tail of a long message
    logic [7:0]              sep;  // Separator byte or first pad byte
    logic [7:0]              cnt;  // Request counter
    logic [495:0]            data; // Seed or key/hash bytes plus padding
    logic [127:0]            len;  // Message length in bits
  } sha_fields_t;

  // One 1024-bit block; words[0] is W0
  typedef union packed {
    sha_word_t [0:15] words;
    sha_fields_t      fields;
  } sha_block_u;

  localparam sha_state_t sha_iv_384 = '{
    a: 64'hcbbb9d5dc1059ed8, b: 64'h629a292a367cd507,
    c: 64'h9159015a3070dd17, d: 64'h152fecd8f70e5939,
    e: 64'h67332667ffc00b31, f: 64'h8eb44a8768581511,
    g: 64'hdb0c2e0d64f98fa7, h: 64'h47b5481dbefa4fa4
  };

  // SHA-512 family round constants
  localparam sha_word_t sha_k [80] = '{
    64'h428a2f98d728ae22, 64'h7137449123ef65cd, 64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
    64'h3956c25bf348b538, 64'h59f111f1b605d019, 64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
    64'hd807aa98a3030242, 64'h12835b0145706fbe, 64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
    64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1, 64'h9bdc06a725c71235, 64'hc19bf174cf692694,
    64'he49b69c19ef14ad2, 64'hefbe4786384f25e3, 64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
    64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483, 64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
    64'h983e5152ee66dfab, 64'ha831c66d2db43210, 64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
    64'hc6e00bf33da88fc2, 64'hd5a79147930aa725, 64'h06ca6351e003826f, 64'h142929670a0e6e70,
    64'h27b70a8546d22ffc, 64'h2e1b21385c26c926, 64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
    64'h650a73548baf63de, 64'h766a0abb3c77b2a8, 64'h81c2c92e47edaee6, 64'h92722c851482353b,
    64'ha2bfe8a14cf10364, 64'ha81a664bbc423001, 64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
    64'hd192e819d6ef5218, 64'hd69906245565a910, 64'hf40e35855771202a, 64'h106aa07032bbd1b8,
    64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53, 64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
    64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb, 64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
    64'h748f82ee5defb2fc, 64'h78a5636f43172f60, 64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
    64'h90befffa23631e28, 64'ha4506cebde82bde9, 64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
    64'hca273eceea26619c, 64'hd186b8c721c0c207, 64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
    64'h06f067aa72176fba, 64'h0a637dc5a2c898a6, 64'h113f9804bef90dae, 64'h1b710b35131c471b,
    64'h28db77f523047d84, 64'h32caab7b40c72493, 64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
    64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a, 64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817
  };

  // Constant for round 0..79
  function automatic sha_word_t sha_round_k(input logic [6:0] round);
    return sha_k[round];
  endfunction

endpackage

/* common/drbg_pkg.sv */
`include "drbg_settings.svh"

package drbg_pkg;

  typedef enum logic {
    mode_seed    = 1'b0,  // NIST SP 800-90A style, seed input
    mode_rfc6979 = 1'b1   // Deterministic ECDSA nonce
  } drbg_mode_e;

  typedef struct packed {
    logic       init;  // Restart K, V and counter
    logic       next;  // Continue from stored K and V
    drbg_mode_e mode;
  } drbg_cmd_t;

  typedef struct packed {
    logic [`DRBG_SEED_SIZE-1:0] seed;
    logic [`DRBG_REG_SIZE-1:0]  privkey;
    logic [`DRBG_REG_SIZE-1:0]  hashed_msg;
  } drbg_data_t;

  typedef struct packed {
    logic                      valid;
    logic [`DRBG_REG_SIZE-1:0] nonce;
  } drbg_result_t;

  // ----------------------------------------------------------------------
  // Controller sequence
  // ----------------------------------------------------------------------
  typedef enum logic [4:0] {
    idle_st, init_st, next_st,
    mode0_k1_st, mode1_k10_st, mode1_k11_st, v1_st,          // First K/V update
    k2_init_st, mode0_k2_st, mode1_k20_st, mode1_k21_st, v2_st, // Second K/V update
    t_st, chck_st, k3_st, v3_st,                             // Candidate and retry
    done_st
  } drbg_state_e;

endpackage

/* sha/sha512_core.sv */
`timescale 1ns/1ns

module sha512_core import sha_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       zeroize,
  input  logic       start,
  input  sha_state_t chain_in,
  input  sha_block_u block,
  output logic       done,
  output sha_state_t chain_out
);

  sha_state_t st;        // Working registers a..h
  sha_word_t  w [16];    // Rolling schedule, w[0] holds W_t
  logic [6:0] round;     // 0..79 rounds, 80 = final add
  logic       busy;

  sha_word_t  t1;
  sha_word_t  t2;
  sha_word_t  w_new;     // W_{t+16}

  function automatic sha_word_t ror(input sha_word_t x, input int unsigned n);
    return (x >> n) | (x << (64 - n));
  endfunction

  // ----------------------------------------------------------------------
  // Round function and schedule expansion
  // ----------------------------------------------------------------------
  always_comb begin
    t1 = st.h + (ror(st.e, 14) ^ ror(st.e, 18) ^ ror(st.e, 41))
         + ((st.e & st.f) ^ (~st.e & st.g))  // Ch
         + sha_round_k(round) + w[0];
    t2 = (ror(st.a, 28) ^ ror(st.a, 34) ^ ror(st.a, 39))
         + ((st.a & st.b) ^ (st.a & st.c) ^ (st.b & st.c));  // Maj
    w_new = (ror(w[14], 19) ^ ror(w[14], 61) ^ (w[14] >> 6))  // sigma1
            + w[9]
            + (ror(w[1], 1) ^ ror(w[1], 8) ^ (w[1] >> 7))     // sigma0
            + w[0];
  end

  // Sequencing: load, 80 rounds, final add
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy  <= 1'b0;
      round <= '0;
      done  <= 1'b0;
    end else if (zeroize) begin
      busy  <= 1'b0;
      round <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;                     // Single cycle pulse
      if (start && !busy) begin
        busy  <= 1'b1;
        round <= '0;
      end else if (busy) begin
        if (round == 7'd80) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          round <= round + 7'd1;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (zeroize) begin
      st        <= '0;
      w         <= '{default: '0};
      chain_out <= '0;
    end else if (start && !busy) begin
      st <= chain_in;
      for (int i = 0; i < 16; i++) begin
        w[i] <= block.words[i];
      end
    end else if (busy && round != 7'd80) begin
      st.a <= t1 + t2;
      st.b <= st.a;
      st.c <= st.b;
      st.d <= st.c;
      st.e <= st.d + t1;
      st.f <= st.e;
      st.g <= st.f;
      st.h <= st.g;
      for (int i = 0; i < 15; i++) begin
        w[i] <= w[i+1];                 // Shift toward W_t
      end
      w[15] <= w_new;
    end else if (busy) begin
      // Feed-forward into the chaining value
      chain_out.a <= chain_in.a + st.a;
      chain_out.b <= chain_in.b + st.b;
      chain_out.c <= chain_in.c + st.c;
      chain_out.d <= chain_in.d + st.d;
      chain_out.e <= chain_in.e + st.e;
      chain_out.f <= chain_in.f + st.f;
      chain_out.g <= chain_in.g + st.g;
      chain_out.h <= chain_in.h + st.h;
    end
  end

endmodule

/* hmac/hmac_core.sv */
`timescale 1ns/1ns

module hmac_core import sha_pkg::*; (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    zeroize,
  input  logic                    start,
  input  logic                    block_next,
  input  logic                    two_block,
  input  logic [sha_digest_w-1:0] key,
  input  sha_block_u              block,
  output logic                    ready,
  output logic                    tag_valid,
  output logic [sha_digest_w-1:0] tag
);

  // Outer message is ipad block plus one digest
  localparam logic [127:0] outer_len = 128'(1024 + sha_digest_w);

  typedef enum logic [2:0] {ph_idle, ph_ipad, ph_msg, ph_wait, ph_opad, ph_outer} phase_e;

  phase_e                  phase;
  logic                    sha_start;
  logic                    sha_done;
  logic                    two_blk_q;   // Latched at start
  logic                    second_q;    // Second message block in flight
  sha_state_t              sha_chain_in;
  sha_state_t              sha_chain_out;
  sha_state_t              chain_q;     // Inner or outer running chain
  sha_block_u              sha_block;
  sha_block_u              outer_block;
  logic [sha_digest_w-1:0] inner_q;     // Inner digest

  sha512_core sha_u (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize   (zeroize),
    .start     (sha_start),
    .chain_in  (sha_chain_in),
    .block     (sha_block),
    .done      (sha_done),
    .chain_out (sha_chain_out)
  );

  assign ready = (phase == ph_idle);

  // ----------------------------------------------------------------------
  // Block and chain selection per phase
  // ----------------------------------------------------------------------
  always_comb begin
    outer_block             = '0;
    outer_block.fields.v    = inner_q;
    outer_block.fields.sep  = 8'h80;        // Pad bit right after digest
    outer_block.fields.len  = outer_len;
    unique case (phase)
      ph_ipad, ph_opad: begin
        sha_chain_in = sha_iv_384;
        sha_block    = sha_block_u'({key, {(1024 - sha_digest_w){1'b0}}}
                       ^ {128{(phase == ph_opad) ? 8'h5c : 8'h36}});
      end
      ph_outer: begin
        sha_chain_in = chain_q;
        sha_block    = outer_block;
      end
      default: begin
        sha_chain_in = chain_q;
        sha_block    = block;               // Caller's pre-padded block
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      phase     <= ph_idle;
      sha_start <= 1'b0;
      tag_valid <= 1'b0;
      two_blk_q <= 1'b0;
      second_q  <= 1'b0;
    end else if (zeroize) begin
      phase     <= ph_idle;
      sha_start <= 1'b0;
      tag_valid <= 1'b0;
      two_blk_q <= 1'b0;
      second_q  <= 1'b0;
    end else begin
      sha_start <= 1'b0;
      unique case (phase)
        ph_idle: if (start) begin
          phase     <= ph_ipad;
          sha_start <= 1'b1;
          tag_valid <= 1'b0;
          two_blk_q <= two_block;
          second_q  <= 1'b0;
        end
        ph_ipad: if (sha_done) begin
          phase     <= ph_msg;
          sha_start <= 1'b1;
        end
        ph_msg: if (sha_done) begin
          if (two_blk_q && !second_q) begin
            phase     <= ph_wait;           // Intermediate tag_valid for the controller
            tag_valid <= 1'b1;
          end else begin
            phase     <= ph_opad;
            sha_start <= 1'b1;
          end
        end
        ph_wait: if (block_next) begin
          phase     <= ph_msg;
          sha_start <= 1'b1;
          second_q  <= 1'b1;
          tag_valid <= 1'b0;
        end
        ph_opad: if (sha_done) begin
          phase     <= ph_outer;
          sha_start <= 1'b1;
        end
        ph_outer: if (sha_done) begin
          phase     <= ph_idle;
          tag_valid <= 1'b1;
        end
        default: phase <= ph_idle;
      endcase
    end
  end

  // Chains and digests
  always_ff @(posedge clk) begin
    if (zeroize) begin
      chain_q <= '0;
      inner_q <= '0;
      tag     <= '0;
    end else if (sha_done) begin
      if (phase == ph_outer) begin
        tag <= sha_chain_out[511 -: sha_digest_w];   // Truncate to SHA-384
      end else begin
        chain_q <= sha_chain_out;
      end
      if (phase == ph_msg) begin
        inner_q <= sha_chain_out[511 -: sha_digest_w];
      end
    end
  end

endmodule

/* design/hmac_drbg.sv */
`timescale 1ns/1ns
`include "drbg_settings.svh"

module hmac_drbg import sha_pkg::*, drbg_pkg::*; #(
  parameter logic [`DRBG_REG_SIZE-1:0] order = `DRBG_P384_ORDER
) (
  input  logic         clk,
  input  logic         reset_n,
  input  logic         zeroize,
  input  drbg_cmd_t    cmd,
  input  drbg_data_t   data,
  output logic         ready,
  output drbg_result_t result
);

  localparam logic [`DRBG_REG_SIZE-1:0] v_init = {(`DRBG_REG_SIZE / 8){8'h01}};

  // Inner message lengths, ipad block included
  localparam int           hdr_w    = 1024 + `DRBG_REG_SIZE + 8 + `DRBG_CNT_SIZE;
  localparam logic [127:0] len_seed = 128'(hdr_w + `DRBG_SEED_SIZE);
  localparam logic [127:0] len_key  = 128'(hdr_w + 2 * `DRBG_REG_SIZE);
  localparam logic [127:0] len_v    = 128'(1024 + `DRBG_REG_SIZE);
  localparam logic [127:0] len_k3   = 128'(1024 + `DRBG_REG_SIZE + 8);

  drbg_state_e               state;
  drbg_state_e               state_next;
  drbg_state_e               state_last;
  logic                      first;           // First cycle in a state
  logic                      tag_valid_last;
  logic                      tag_edge;
  logic                      accept;
  logic                      is_rfc;
  logic                      reject;
  logic [7:0]                sep_byte;
  logic [`DRBG_REG_SIZE-1:0] k_q;
  logic [`DRBG_REG_SIZE-1:0] v_q;
  logic [`DRBG_CNT_SIZE-1:0] cnt_q;
  logic                      ready_q;
  drbg_result_t              result_q;

  logic                      hmac_start;
  logic                      hmac_block_next;
  logic                      hmac_two_block;
  logic                      hmac_ready;
  logic                      hmac_tag_valid;
  logic [`DRBG_REG_SIZE-1:0] hmac_tag;
  sha_block_u                hmac_block;

  hmac_core hmac_k (
    .clk        (clk),
    .reset_n    (reset_n),
    .zeroize    (zeroize),
    .start      (hmac_start),
    .block_next (hmac_block_next),
    .two_block  (hmac_two_block),
    .key        (k_q),
    .block      (hmac_block),
    .ready      (hmac_ready),
    .tag_valid  (hmac_tag_valid),
    .tag        (hmac_tag)
  );

  assign first    = (state != state_last);
  assign tag_edge = hmac_tag_valid & ~tag_valid_last;
  assign accept   = ready_q & hmac_ready & (cmd.init ^ cmd.next);  // Exactly one command
  assign is_rfc   = (cmd.mode == mode_rfc6979);
  assign reject   = (hmac_tag == '0) || (hmac_tag >= order);
  assign sep_byte = (state inside {mode0_k2_st, mode1_k20_st}) ? 8'h01 : 8'h00;
  assign hmac_two_block = (state inside {mode1_k10_st, mode1_k20_st});
  assign ready    = ready_q;
  assign result   = result_q;

  // ----------------------------------------------------------------------
  // Block formatting through the field view
  // ----------------------------------------------------------------------
  always_comb begin
    hmac_block = '0;
    unique case (state)
      mode0_k1_st, mode0_k2_st: begin   // V || sep || cnt || seed
        hmac_block.fields.v    = v_q;
        hmac_block.fields.sep  = sep_byte;
        hmac_block.fields.cnt  = cnt_q;
        hmac_block.fields.data = {data.seed, 1'b1, {(495 - `DRBG_SEED_SIZE){1'b0}}};
        hmac_block.fields.len  = len_seed;
      end
      mode1_k10_st, mode1_k20_st: begin // V || sep || cnt || key || hash head
        hmac_block.fields.v    = v_q;
        hmac_block.fields.sep  = sep_byte;
        hmac_block.fields.cnt  = cnt_q;
        hmac_block.fields.data = {data.privkey, data.hashed_msg[`DRBG_REG_SIZE-1 -: 112]};
        hmac_block.fields.len  = data.hashed_msg[`DRBG_REG_SIZE-113 -: 128];
      end
      mode1_k11_st, mode1_k21_st: begin // Hash tail, pad, length
        hmac_block.fields.v   = {data.hashed_msg[143:0], 1'b1, 239'b0};
        hmac_block.fields.len = len_key;
      end
      v1_st, v2_st, t_st, v3_st: begin
        hmac_block.fields.v   = v_q;
        hmac_block.fields.sep = 8'h80;
        hmac_block.fields.len = len_v;
      end
      k3_st: begin                      // V || 0x00 only
        hmac_block.fields.v   = v_q;
        hmac_block.fields.cnt = 8'h80;  // Pad byte lands in cnt slot
        hmac_block.fields.len = len_k3;
      end
      default: ;
    endcase
  end

  // Next state
  always_comb begin
    state_next = state;
    unique case (state)
      idle_st:      if (accept) state_next = cmd.init ? init_st : next_st;
      init_st,
      next_st:      state_next = is_rfc ? mode1_k10_st : mode0_k1_st;
      mode0_k1_st:  if (tag_edge) state_next = v1_st;
      mode1_k10_st: if (tag_edge) state_next = mode1_k11_st;
      mode1_k11_st: if (tag_edge) state_next = v1_st;
      v1_st:        if (tag_edge) state_next = k2_init_st;
      k2_init_st:   state_next = is_rfc ? mode1_k20_st : mode0_k2_st;
      mode0_k2_st:  if (tag_edge) state_next = v2_st;
      mode1_k20_st: if (tag_edge) state_next = mode1_k21_st;
      mode1_k21_st: if (tag_edge) state_next = v2_st;
      v2_st:        if (tag_edge) state_next = t_st;
      t_st:         if (tag_edge) state_next = chck_st;
      chck_st:      state_next = reject ? k3_st : done_st;  // Candidate out of [1, order-1]
      k3_st:        if (tag_edge) state_next = v3_st;
      v3_st:        if (tag_edge) state_next = t_st;
      default:      state_next = idle_st;                   // done_st
    endcase
  end

  // ----------------------------------------------------------------------
  // Registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state           <= idle_st;
      state_last      <= idle_st;
      tag_valid_last  <= 1'b0;
      hmac_start      <= 1'b0;
      hmac_block_next <= 1'b0;
      ready_q         <= 1'b0;
      result_q        <= '0;
      k_q             <= '0;
      v_q             <= '0;
      cnt_q           <= '0;
    end else if (zeroize) begin
      state           <= idle_st;
      state_last      <= idle_st;
      tag_valid_last  <= 1'b0;
      hmac_start      <= 1'b0;
      hmac_block_next <= 1'b0;
      ready_q         <= 1'b0;
      result_q        <= '0;
      k_q             <= '0;
      v_q             <= '0;
      cnt_q           <= '0;
    end else begin
      state           <= state_next;
      state_last      <= state;
      tag_valid_last  <= hmac_tag_valid;
      ready_q         <= (state == idle_st) && !accept;
      // One start per HMAC state, issued after K/V settle
      hmac_start      <= first && (state inside {mode0_k1_st, mode1_k10_st, v1_st,
                         mode0_k2_st, mode1_k20_st, v2_st, t_st, k3_st, v3_st});
      hmac_block_next <= first && (state inside {mode1_k11_st, mode1_k21_st});

      if (accept) begin
        result_q.valid <= 1'b0;
      end else if (state == done_st) begin
        result_q.valid <= 1'b1;
        result_q.nonce <= hmac_tag;
      end

      if (first) begin
        unique case (state)
          init_st: begin
            k_q   <= '0;
            v_q   <= v_init;
            cnt_q <= '0;
          end
          next_st:    cnt_q <= cnt_q + 1'b1;
          k2_init_st: begin
            v_q   <= hmac_tag;                // V from first V update
            cnt_q <= cnt_q + 1'b1;
          end
          v1_st, v2_st, v3_st: k_q <= hmac_tag;  // K from preceding K update
          t_st, chck_st:       v_q <= hmac_tag;  // chck_st keeps V = T
          default: ;
        endcase
      end
    end
  end

endmodule

/* sim/hmac_drbg_asserts.sv */
`timescale 1ns/1ns
`include "drbg_settings.svh"

module hmac_drbg_asserts import drbg_pkg::*; #(
  parameter logic [`DRBG_REG_SIZE-1:0] order = `DRBG_P384_ORDER
) (
  input logic         clk,
  input logic         reset_n,
  input logic         zeroize,
  input logic         ready,
  input logic         hmac_start,
  input drbg_state_e  state,
  input drbg_result_t result
);

  int unsigned fail_count = 0;  // Failed assertions so far

  // ----------------------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------------------
  valid_from_done: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(result.valid) |-> $past(state) == done_st)
    else begin
      fail_count++;
      $error("result valid rose outside done_st");
    end

  // No new command while a request is in flight
  busy_not_ready: assert property (@(posedge clk) disable iff (!reset_n)
    (!result.valid && state != idle_st) |-> !ready)
    else begin
      fail_count++;
      $error("ready high while a request is running");
    end

  start_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    hmac_start |=> !hmac_start)
    else begin
      fail_count++;
      $error("HMAC start longer than one cycle");
    end

  // Nonce in [1, order-1]
  nonce_range: assert property (@(posedge clk) disable iff (!reset_n)
    result.valid |-> (result.nonce != '0) && (result.nonce < order))
    else begin
      fail_count++;
      $error("valid nonce outside the group range");
    end

  zeroize_clears: assert property (@(posedge clk) disable iff (!reset_n)
    zeroize |=> !result.valid)
    else begin
      fail_count++;
      $error("valid still high after zeroize");
    end

endmodule

bind hmac_drbg hmac_drbg_asserts #(.order(order)) asserts_inst (
  .clk        (clk),
  .reset_n    (reset_n),
  .zeroize    (zeroize),
  .ready      (ready),
  .hmac_start (hmac_start),
  .state      (state),
  .result     (result)
);

/* sim/hmac_drbg_tb.sv */
`timescale 1ns/1ns
`include "drbg_settings.svh"

module hmac_drbg_tb import drbg_pkg::*; ();

  // Test order 2^383 + 1 rejects about half of all candidates
  localparam logic [`DRBG_REG_SIZE-1:0] test_order = {1'b1, {(`DRBG_REG_SIZE-2){1'b0}}, 1'b1};
  localparam int attempt_cycles = 8 * 5 * 5 * 83;  // Candidates x HMACs x compressions x cycles
  localparam int reset_cycles   = 8;

  typedef struct packed {
    logic [63:0]                op;       // init, next or zeroize as text
    drbg_mode_e                 mode;
    logic [`DRBG_SEED_SIZE-1:0] seed;
    logic [`DRBG_REG_SIZE-1:0]  privkey;
    logic [`DRBG_REG_SIZE-1:0]  hashed_msg;
    int                         same_as;  // Earlier vector to repeat or -1
  } vector_t;

  logic                      clk = 1'b0;
  logic                      reset_n;
  logic                      zeroize;
  drbg_cmd_t                 cmd;
  drbg_data_t                data;
  logic                      ready;
  drbg_result_t              result;
  vector_t                   vectors[$];
  logic [`DRBG_REG_SIZE-1:0] nonce_log[$];  // One entry per vector
  int unsigned               cycles = 0;
  int unsigned               cycle_limit = 0;

  hmac_drbg #(.order(test_order)) hmac_drbg_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .zeroize (zeroize),
    .cmd     (cmd),
    .data    (data),
    .ready   (ready),
    .result  (result)
  );

  always #2 clk = ~clk;

  task automatic fail_run();
    $display("Testbench failed");
    $fatal(1, "run stopped");
  endtask

  // Hang guard and bound assertion watch
  always @(negedge clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("DUT hung, no result within %0d cycles", cycle_limit);
      fail_run();
    end else if (hmac_drbg_inst.asserts_inst.fail_count != 0) begin
      $display("a bound assertion on the DUT failed at %0t ns", $time);
      fail_run();
    end
  end

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic check_result(input drbg_result_t got, input drbg_result_t exp,
                              input string name);
    if (got !== exp) begin
      $display("mismatch at %0t ns %s expected %h got %h", $time, name, exp, got);
      fail_run();
    end
  endtask

  task automatic check_ready(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("mismatch at %0t ns %s expected %b got %b", $time, name, exp, got);
      fail_run();
    end
  endtask

  task automatic check_range(input drbg_result_t got);
    if (got.nonce == '0 || got.nonce >= test_order) begin
      $display("nonce %h at %0t ns is not in 1 to order-1", got.nonce, $time);
      fail_run();
    end
  endtask

  task automatic read_golden();
    int                         fd;
    int                         n;
    int                         mode;
    int                         same_as;
    string                      line;
    logic [63:0]                op;
    logic [`DRBG_SEED_SIZE-1:0] seed;
    logic [`DRBG_REG_SIZE-1:0]  key;
    logic [`DRBG_REG_SIZE-1:0]  hash;
    fd = $fopen("sim/hmac_drbg_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open the golden vector file");
      fail_run();
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#") begin         // Skip column notes
        n = $sscanf(line, "%s %d %h %h %h %d", op, mode, seed, key, hash, same_as);
        if (n == 6) begin
          vectors.push_back('{op: op, mode: drbg_mode_e'(mode[0]), seed: seed,
                              privkey: key, hashed_msg: hash, same_as: same_as});
        end
      end
    end
    $fclose(fd);
  endtask

  // ----------------------------------------------------------------------
  // Stimulus driven on the falling edge
  // ----------------------------------------------------------------------
  task automatic run_command(input vector_t vec);
    drbg_result_t held;
    drbg_result_t exp;
    int           gap;
    cmd.init = (vec.op == "init");
    cmd.next = (vec.op == "next");
    cmd.mode = vec.mode;
    data     = '{seed: vec.seed, privkey: vec.privkey, hashed_msg: vec.hashed_msg};
    @(negedge clk);
    cmd.init = 1'b0;
    cmd.next = 1'b0;
    check_ready(ready, 1'b0, "ready");              // Command taken and DUT busy
    while (!result.valid) @(negedge clk);
    check_ready(ready, 1'b0, "ready");              // Rises one cycle after valid
    held = result;
    check_range(held);
    if (vec.same_as >= 0) begin
      exp = '{valid: 1'b1, nonce: nonce_log[vec.same_as]};
      check_result(held, exp, "result");
    end
    nonce_log.push_back(held.nonce);
    @(negedge clk);
    check_ready(ready, 1'b1, "ready");
    gap = $urandom_range(12, 1);
    repeat (gap) begin                               // Result holds while idle
      check_result(result, held, "result");
      @(negedge clk);
    end
  endtask

  task automatic run_zeroize(input vector_t vec);
    drbg_result_t cleared;
    int           delay;
    cleared  = '0;
    cmd.init = 1'b1;
    cmd.mode = vec.mode;
    data     = '{seed: vec.seed, privkey: vec.privkey, hashed_msg: vec.hashed_msg};
    @(negedge clk);
    cmd.init = 1'b0;
    delay    = $urandom_range(600, 20);             // Well inside the first HMACs
    repeat (delay) @(negedge clk);
    zeroize = 1'b1;
    @(negedge clk);
    zeroize = 1'b0;
    check_result(result, cleared, "result");
    check_ready(ready, 1'b0, "ready");
    @(negedge clk);
    check_ready(ready, 1'b1, "ready");
    nonce_log.push_back('0);
  endtask

  initial begin
    void'($urandom(59704));
    reset_n = 1'b0;
    zeroize = 1'b0;
    cmd     = '0;
    data    = '0;
    read_golden();
    if (vectors.size() == 0) begin
      $display("golden vector file holds no vectors");
      fail_run();
    end
    cycle_limit = vectors.size() * attempt_cycles + reset_cycles + 2;
    repeat (reset_cycles) @(negedge clk);
    check_result(result, '0, "result");             // Reset values
    check_ready(ready, 1'b0, "ready");
    reset_n = 1'b1;
    @(negedge clk);
    check_result(result, '0, "result");
    check_ready(ready, 1'b1, "ready");              // One cycle after release
    foreach (vectors[i]) begin
      if (vectors[i].op == "zeroize") begin
        run_zeroize(vectors[i]);
      end else begin
        run_command(vectors[i]);
      end
    end
    if (hmac_drbg_inst.asserts_inst.fail_count != 0) begin
      $display("a bound assertion on the DUT failed");
      fail_run();
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

/* hmac_drbg.f */
+incdir+common
common/sha_pkg.sv
common/drbg_pkg.sv
sha/sha512_core.sv
hmac/hmac_core.sv
design/hmac_drbg.sv
sim/hmac_drbg_asserts.sv
sim/hmac_drbg_tb.sv

/* sim/hmac_drbg_golden.txt */
# op mode seed privkey hashed_msg same_as (hex for the three data fields)
# same_as is the index of an earlier vector whose nonce must repeat, -1 only asks for range
init    0 0123456789abcdeffedcba9876543210 0 0 -1
next    0 0123456789abcdeffedcba9876543210 0 0 -1
next    0 0123456789abcdeffedcba9876543210 0 0 -1
init    1 0 6b9d3dad2e1b8c1c05b19875b6659f4d af2bdbe1aa9b6ec1e2ade1d694f41fc7 -1
next    1 0 6b9d3dad2e1b8c1c05b19875b6659f4d af2bdbe1aa9b6ec1e2ade1d694f41fc7 -1
init    1 0 9a4d6792295a7f730fc3f2b49cbc0f62 e8b0c44298fc1c149afbf4c8996fb924 -1
init    0 0123456789abcdeffedcba9876543210 0 0 0
next    0 0123456789abcdeffedcba9876543210 0 0 1
zeroize 1 0 6b9d3dad2e1b8c1c05b19875b6659f4d af2bdbe1aa9b6ec1e2ade1d694f41fc7 -1
init    1 0 6b9d3dad2e1b8c1c05b19875b6659f4d af2bdbe1aa9b6ec1e2ade1d694f41fc7 3
next    1 0 6b9d3dad2e1b8c1c05b19875b6659f4d af2bdbe1aa9b6ec1e2ade1d694f41fc7 4
zeroize 0 0123456789abcdeffedcba9876543210 0 0 -1
init    0 0123456789abcdeffedcba9876543210 0 0 0
init    0 00112233445566778899aabbccddeeff 0 0 -1
